//--- design/aes_pkg.sv
// aes shared definitions
// block and word types, counter widths, round kinds and gf(2^8) helpers

package aes_pkg;

  // --------------------
  // data types
  // --------------------

  // one state block or one round key
  typedef logic [127:0] block_t;

  // one column, the s-box unit
  typedef logic [31:0] word_t;

  // round number 0..10
  typedef logic [3:0] round_ctr_t;

  // s-box word index 0..3
  typedef logic [1:0] sword_ctr_t;

  // kind of round being applied
  typedef enum logic [1:0] {
    init_round  = 2'd0,
    main_round  = 2'd1,
    final_round = 2'd2
  } round_kind_t;

  // aes-128 round count
  localparam round_ctr_t num_rounds = 4'd10;

  // --------------------
  // gf(2^8) arithmetic
  // --------------------

  // multiply by x, reduce with 0x1b when the top bit falls out
  function automatic logic [7:0] gm2(input logic [7:0] op);
    logic [7:0] shifted;
    shifted = {op[6:0], 1'b0};
    return shifted ^ (8'h1b & {8{op[7]}});
  endfunction

  // multiply by x+1
  function automatic logic [7:0] gm3(input logic [7:0] op);
    return gm2(op) ^ op;
  endfunction

endpackage

//--- design/aes_sbox_word.sv
// forward aes s-box on one 32-bit word
// four independent byte lookups, purely combinational

`timescale 1ns/1ps

module aes_sbox_word (
  input  aes_pkg::word_t word,
  output aes_pkg::word_t sub_word
);

  // table row picked by the high nibble, byte by the low nibble
  function automatic logic [7:0] sbox_byte(input logic [7:0] b);
    logic [127:0] row;
    case (b[7:4])
      4'h0: row = 128'h637c777bf26b6fc53001672bfed7ab76;
      4'h1: row = 128'hca82c97dfa5947f0add4a2af9ca472c0;
      4'h2: row = 128'hb7fd9326363ff7cc34a5e5f171d83115;
      4'h3: row = 128'h04c723c31896059a071280e2eb27b275;
      4'h4: row = 128'h09832c1a1b6e5aa0523bd6b329e32f84;
      4'h5: row = 128'h53d100ed20fcb15b6acbbe394a4c58cf;
      4'h6: row = 128'hd0efaafb434d338545f9027f503c9fa8;
      4'h7: row = 128'h51a3408f929d38f5bcb6da2110fff3d2;
      4'h8: row = 128'hcd0c13ec5f974417c4a77e3d645d1973;
      4'h9: row = 128'h60814fdc222a908846eeb814de5e0bdb;
      4'ha: row = 128'he0323a0a4906245cc2d3ac629195e479;
      4'hb: row = 128'he7c8376d8dd54ea96c56f4ea657aae08;
      4'hc: row = 128'hba78252e1ca6b4c6e8dd741f4bbd8b8a;
      4'hd: row = 128'h703eb5664803f60e613557b986c11d9e;
      4'he: row = 128'he1f8981169d98e949b1e87e9ce5528df;
      default: row = 128'h8ca1890dbfe6426841992d0fb054bb16;
    endcase
    // entry 0 sits in the top byte of the row
    return row[8 * (15 - b[3:0]) +: 8];
  endfunction

  // --------------------
  // byte lanes
  // --------------------

  // row 0 byte of the column
  assign sub_word[31:24] = sbox_byte(word[31:24]);
  // row 1
  assign sub_word[23:16] = sbox_byte(word[23:16]);
  // row 2
  assign sub_word[15:8]  = sbox_byte(word[15:8]);
  // row 3
  assign sub_word[7:0]   = sbox_byte(word[7:0]);

endmodule

//--- design/aes_key_schedule.sv
// aes-128 key schedule, one round key per step
// round_key shows the cipher key while loading, else the next round key

`timescale 1ns/1ps

module aes_key_schedule (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            load,
  input  logic            step,
  input  aes_pkg::block_t key,
  output aes_pkg::block_t round_key
);
  import aes_pkg::*;

  // w[3] is the first fips word, w[0] the last
  block_t      key_reg;
  word_t [3:0] w;
  word_t [3:0] nw;
  word_t       rot_word;
  word_t       sub_word;
  word_t       temp;
  logic [7:0]  rcon_reg;

  assign w = key_reg;

  // rotword on the last word, then subword through the shared table
  assign rot_word = {w[0][23:0], w[0][31:24]};

  aes_sbox_word u_sbox (
    .word     (rot_word),
    .sub_word (sub_word)
  );

  assign temp = sub_word ^ {rcon_reg, 24'h000000};

  // xor chain across the four words
  always_comb
  begin
    nw[3] = w[3] ^ temp;
    nw[2] = w[2] ^ nw[3];
    nw[1] = w[1] ^ nw[2];
    nw[0] = w[0] ^ nw[1];
  end

  // key for the AddRoundKey applied on this edge
  assign round_key = load ? key : nw;

  // --------------------
  // registers
  // --------------------

  // rcon doubles per round, 01 02 04 .. 80 1b 36
  always_ff @(posedge clk)
  begin
    if (!reset_n)
      rcon_reg <= 8'h01;
    else if (load)
      rcon_reg <= 8'h01;
    else if (step)
      rcon_reg <= gm2(rcon_reg);
  end

  always_ff @(posedge clk)
  begin
    if (load)
      key_reg <= key;
    else if (step)
      key_reg <= nw;
  end

  // a new block never starts while a round is being finished
  a_step_load_excl: assert property (@(posedge clk) disable iff (!reset_n)
    !(step && load));

endmodule

//--- design/aes_round_state.sv
// aes round state with word-serial SubBytes
// applies ShiftRows, MixColumns and AddRoundKey on update, holds the result

`timescale 1ns/1ps

module aes_round_state (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 load,
  input  logic                 update,
  input  logic                 done,
  input  aes_pkg::block_t      block,
  input  aes_pkg::block_t      round_key,
  input  aes_pkg::sword_ctr_t  sword_ctr,
  input  aes_pkg::round_kind_t round_kind,
  output aes_pkg::block_t      result,
  output logic                 valid
);
  import aes_pkg::*;

  block_t           state_reg;
  word_t [3:0]      state_w;
  word_t [3:0]      sub_buf;
  word_t            sbox_in;
  word_t            sbox_out;
  block_t           next_state;

  // byte 0 is the top byte, byte 4c+r is row r of column c
  logic [0:15][7:0] sub_b;
  logic [0:15][7:0] shift_b;
  logic [0:15][7:0] mix_b;

  // --------------------
  // subbytes
  // --------------------

  // column 0 lives in the top word
  assign state_w = state_reg;
  assign sbox_in = state_w[2'd3 - sword_ctr];

  aes_sbox_word u_sbox (
    .word     (sbox_in),
    .sub_word (sbox_out)
  );

  // buffer written every cycle
  // the four subbytes cycles refill it fully before each update
  always_ff @(posedge clk)
  begin
    sub_buf[2'd3 - sword_ctr] <= sbox_out;
  end

  assign sub_b = sub_buf;

  // --------------------
  // round transforms
  // --------------------

  always_comb
  begin
    // shiftrows, row r rotates left by r columns
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
      begin
        shift_b[4 * c + r] = sub_b[4 * ((c + r) % 4) + r];
      end
    end

    // mixcolumns per column
    for (int c = 0; c < 4; c++)
    begin
      mix_b[4 * c]     = gm2(shift_b[4 * c]) ^ gm3(shift_b[4 * c + 1]) ^
                         shift_b[4 * c + 2] ^ shift_b[4 * c + 3];
      mix_b[4 * c + 1] = shift_b[4 * c] ^ gm2(shift_b[4 * c + 1]) ^
                         gm3(shift_b[4 * c + 2]) ^ shift_b[4 * c + 3];
      mix_b[4 * c + 2] = shift_b[4 * c] ^ shift_b[4 * c + 1] ^
                         gm2(shift_b[4 * c + 2]) ^ gm3(shift_b[4 * c + 3]);
      mix_b[4 * c + 3] = gm3(shift_b[4 * c]) ^ shift_b[4 * c + 1] ^
                         shift_b[4 * c + 2] ^ gm2(shift_b[4 * c + 3]);
    end

    // addroundkey, final round has no mixcolumns
    if (round_kind == final_round)
      next_state = shift_b ^ round_key;
    else
      next_state = mix_b ^ round_key;
  end

  // load is the init round, round_key carries the cipher key then
  always_ff @(posedge clk)
  begin
    if (load)
      state_reg <= block ^ round_key;
    else if (update)
      state_reg <= next_state;
  end

  // --------------------
  // output side
  // --------------------

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      result <= '0;
      valid  <= 1'b0;
    end
    else
    begin
      valid <= done;
      // result held until the next block finishes
      if (done)
        result <= state_reg;
    end
  end

  // one result per block
  a_valid_pulse: assert property (@(posedge clk) disable iff (!reset_n)
    valid |=> !valid);

endmodule

//--- design/aes_enc_ctrl.sv
// aes encryption sequencer
// fsm with the s-box word counter and the round counter

`timescale 1ns/1ps

module aes_enc_ctrl (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 start,
  output logic                 load,
  output logic                 update,
  output logic                 done,
  output logic                 ready,
  output aes_pkg::sword_ctr_t  sword_ctr,
  output aes_pkg::round_kind_t round_kind
);
  import aes_pkg::*;

  typedef enum logic [1:0] {
    idle         = 2'd0,
    sub_bytes    = 2'd1,
    round_update = 2'd2
  } ctrl_state_t;

  ctrl_state_t ctrl_reg;
  sword_ctr_t  sword_ctr_reg;
  round_ctr_t  round_ctr_reg;
  logic        done_reg;

  // --------------------
  // outputs
  // --------------------

  // ready stays low through the done cycle, rises with valid
  assign ready     = (ctrl_reg == idle) && !done_reg;
  assign load      = start && ready;
  assign update    = (ctrl_reg == round_update);
  assign done      = done_reg;
  assign sword_ctr = sword_ctr_reg;

  always_comb
  begin
    if (ctrl_reg != round_update)
      round_kind = init_round;
    else if (round_ctr_reg == num_rounds)
      round_kind = final_round;
    else
      round_kind = main_round;
  end

  // --------------------
  // fsm and counters
  // --------------------

  // five cycles per round, four subbytes words then one update
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      ctrl_reg      <= idle;
      sword_ctr_reg <= '0;
      round_ctr_reg <= '0;
      done_reg      <= 1'b0;
    end
    else
    begin
      done_reg <= 1'b0;
      case (ctrl_reg)
        idle:
        begin
          if (load)
          begin
            ctrl_reg      <= sub_bytes;
            sword_ctr_reg <= '0;
            round_ctr_reg <= round_ctr_t'(1);
          end
        end
        sub_bytes:
        begin
          // wraps back to word 0 on the move to update
          sword_ctr_reg <= sword_ctr_reg + 1'b1;
          if (sword_ctr_reg == 2'd3)
            ctrl_reg <= round_update;
        end
        round_update:
        begin
          if (round_ctr_reg == num_rounds)
          begin
            ctrl_reg <= idle;
            done_reg <= 1'b1;
          end
          else
          begin
            round_ctr_reg <= round_ctr_reg + 1'b1;
            ctrl_reg      <= sub_bytes;
          end
        end
        default:
          ctrl_reg <= idle;
      endcase
    end
  end

  a_round_bound: assert property (@(posedge clk) disable iff (!reset_n)
    round_ctr_reg <= num_rounds);

endmodule

//--- design/aes_encipher.sv
// aes-128 iterative encryption core
// start strobe in, ciphertext with a one-cycle valid out

`timescale 1ns/1ps

module aes_encipher (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            start,
  input  aes_pkg::block_t block,
  input  aes_pkg::block_t key,
  output logic            ready,
  output aes_pkg::block_t result,
  output logic            valid
);
  import aes_pkg::*;

  logic        load;
  logic        update;
  logic        done;
  sword_ctr_t  sword_ctr;
  round_kind_t round_kind;
  block_t      round_key;

  // --------------------
  // control
  // --------------------

  aes_enc_ctrl u_ctrl (
    .clk        (clk),
    .reset_n    (reset_n),
    .start      (start),
    .load       (load),
    .update     (update),
    .done       (done),
    .ready      (ready),
    .sword_ctr  (sword_ctr),
    .round_kind (round_kind)
  );

  // key advances on the same edge as the state update
  aes_key_schedule u_key (
    .clk       (clk),
    .reset_n   (reset_n),
    .load      (load),
    .step      (update),
    .key       (key),
    .round_key (round_key)
  );

  // --------------------
  // datapath
  // --------------------

  aes_round_state u_state (
    .clk        (clk),
    .reset_n    (reset_n),
    .load       (load),
    .update     (update),
    .done       (done),
    .block      (block),
    .round_key  (round_key),
    .sword_ctr  (sword_ctr),
    .round_kind (round_kind),
    .result     (result),
    .valid      (valid)
  );

endmodule

//--- tests/aes_ref.svh
// aes-128 reference model for the testbench
// s-box built from the gf(2^8) inverse and the affine map, plus the lfsr step

`ifndef AES_REF_SVH
`define AES_REF_SVH

// shift-and-add multiply, reduced by 0x1b
function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
  logic [7:0] p;
  logic [7:0] aa;
  p = 8'h00;
  aa = a;
  for (int i = 0; i < 8; i++)
  begin
    if (b[i])
      p = p ^ aa;
    aa = {aa[6:0], 1'b0} ^ (aa[7] ? 8'h1b : 8'h00);
  end
  return p;
endfunction

// inverse as x^254 = x^2 * x^4 * .. * x^128, zero stays zero
function automatic logic [7:0] sbox_calc(input logic [7:0] x);
  logic [7:0] sq;
  logic [7:0] inv;
  sq = x;
  inv = 8'h01;
  for (int k = 1; k < 8; k++)
  begin
    sq = gf_mul(sq, sq);
    inv = gf_mul(inv, sq);
  end
  // affine map, xor of four left rotations plus 0x63
  return inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^ {inv[4:0], inv[7:5]} ^
         {inv[3:0], inv[7:4]} ^ 8'h63;
endfunction

// byte i of a block is the i-th byte from the top, column i/4, row i%4
function automatic logic [127:0] aes_ref_encrypt(input logic [127:0] key_in,
                                                 input logic [127:0] pt);
  logic [31:0]  w [0:43];
  logic [7:0]   st [0:15];
  logic [7:0]   sh [0:15];
  logic [31:0]  tmp;
  logic [7:0]   rc;
  logic [127:0] ct;
  // full key expansion up front
  for (int i = 0; i < 4; i++)
    w[i] = key_in[127 - 32 * i -: 32];
  rc = 8'h01;
  for (int i = 4; i < 44; i++)
  begin
    tmp = w[i - 1];
    if (i % 4 == 0)
    begin
      tmp = {sbox_calc(tmp[23:16]), sbox_calc(tmp[15:8]), sbox_calc(tmp[7:0]),
             sbox_calc(tmp[31:24])} ^ {rc, 24'h000000};
      rc = gf_mul(rc, 8'h02);
    end
    w[i] = w[i - 4] ^ tmp;
  end
  for (int i = 0; i < 16; i++)
    st[i] = pt[127 - 8 * i -: 8] ^ w[i / 4][31 - 8 * (i % 4) -: 8];
  for (int rnd = 1; rnd <= 10; rnd++)
  begin
    for (int i = 0; i < 16; i++)
      st[i] = sbox_calc(st[i]);
    // row r moves left by r columns
    for (int c = 0; c < 4; c++)
    begin
      for (int r = 0; r < 4; r++)
        sh[4 * c + r] = st[4 * ((c + r) % 4) + r];
    end
    for (int c = 0; c < 4; c++)
    begin
      if (rnd < 10)
      begin
        st[4 * c]     = gf_mul(sh[4 * c], 8'h02) ^ gf_mul(sh[4 * c + 1], 8'h03) ^
                        sh[4 * c + 2] ^ sh[4 * c + 3];
        st[4 * c + 1] = sh[4 * c] ^ gf_mul(sh[4 * c + 1], 8'h02) ^
                        gf_mul(sh[4 * c + 2], 8'h03) ^ sh[4 * c + 3];
        st[4 * c + 2] = sh[4 * c] ^ sh[4 * c + 1] ^ gf_mul(sh[4 * c + 2], 8'h02) ^
                        gf_mul(sh[4 * c + 3], 8'h03);
        st[4 * c + 3] = gf_mul(sh[4 * c], 8'h03) ^ sh[4 * c + 1] ^ sh[4 * c + 2] ^
                        gf_mul(sh[4 * c + 3], 8'h02);
      end
      else
      begin
        for (int r = 0; r < 4; r++)
          st[4 * c + r] = sh[4 * c + r];
      end
    end
    for (int i = 0; i < 16; i++)
      st[i] = st[i] ^ w[4 * rnd + i / 4][31 - 8 * (i % 4) -: 8];
  end
  for (int i = 0; i < 16; i++)
    ct[127 - 8 * i -: 8] = st[i];
  return ct;
endfunction

// 32-bit fibonacci lfsr, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

`endif

//--- tests/tb_aes_encipher.sv
// testbench for the aes-128 encryption core
// fips vector, random blocks, ignored starts and result hold

`timescale 1ns/1ps

module tb_aes_encipher;

  `include "aes_ref.svh"

  // fips 1, random 20, busy start 1, hold and back to back 2
  localparam int num_ops = 24;

  logic         clk;
  logic         reset_n;
  logic         start;
  logic [127:0] block;
  logic [127:0] key;
  logic         ready;
  logic [127:0] result;
  logic         valid;

  logic [31:0]  lfsr_reg = 32'd4;
  logic [127:0] exp_q[$];
  int           edge_q[$];
  int           edge_count = 0;
  int           done_count = 0;
  int           issued = 0;
  logic [127:0] exp_val;
  int           acc_edge;
  logic [127:0] k;
  logic [127:0] b;
  logic [127:0] held;

  aes_encipher dut (
    .clk     (clk),
    .reset_n (reset_n),
    .start   (start),
    .block   (block),
    .key     (key),
    .ready   (ready),
    .result  (result),
    .valid   (valid)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------
  // helpers
  // --------------------

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  // one lfsr step per bit
  task automatic make_random(output logic [127:0] val);
    for (int i = 0; i < 128; i++)
    begin
      val = {val[126:0], lfsr_reg[31]};
      lfsr_reg = lfsr_step(lfsr_reg);
    end
  endtask

  // one-cycle start strobe once the core is ready
  task automatic run_op(input logic [127:0] op_key, input logic [127:0] op_block);
    @(negedge clk);
    while (!ready)
      @(negedge clk);
    key = op_key;
    block = op_block;
    start = 1'b1;
    issued++;
    @(negedge clk);
    start = 1'b0;
  endtask

  task automatic wait_results();
    wait (done_count == issued);
  endtask

  // --------------------
  // monitor and compare
  // --------------------

  // accepted starts queue the reference ciphertext
  always @(posedge clk)
  begin
    edge_count = edge_count + 1;
    if (reset_n && start && ready)
    begin
      exp_q.push_back(aes_ref_encrypt(key, block));
      edge_q.push_back(edge_count);
    end
  end

  always @(negedge clk)
  begin
    if (valid)
    begin
      assert (exp_q.size() > 0)
        else fail_now("valid pulse without an accepted start");
      exp_val = exp_q.pop_front();
      acc_edge = edge_q.pop_front();
      assert (result == exp_val)
        else fail_now($sformatf("mismatch at %0t: result %h expected %h",
                                $time, result, exp_val));
      assert (edge_count - acc_edge == 51)
        else fail_now($sformatf("valid came %0d edges after start, not 51",
                                edge_count - acc_edge));
      done_count++;
    end
  end

  // watchdog
  initial
  begin
    repeat ((num_ops + 2) * 60) @(posedge clk);
    fail_now("timeout waiting for the core to finish");
  end

  // --------------------
  // stimulus
  // --------------------

  initial
  begin
    reset_n = 1'b0;
    start = 1'b0;
    block = '0;
    key = '0;
    repeat (8) @(negedge clk);
    reset_n = 1'b1;

    // first the idle state after reset
    assert (ready && !valid)
      else fail_now("ready low or valid high after reset");
    assert (result == '0)
      else fail_now($sformatf("mismatch at %0t: reset result %h", $time, result));

    // then the fips-197 appendix c.1 vector
    assert (aes_ref_encrypt(128'h000102030405060708090a0b0c0d0e0f,
                            128'h00112233445566778899aabbccddeeff) ==
            128'h69c4e0d86a7b0430d8cdb78070b4c55a)
      else fail_now("reference model disagrees with the fips-197 vector");
    run_op(128'h000102030405060708090a0b0c0d0e0f, 128'h00112233445566778899aabbccddeeff);
    wait_results();
    assert (result == 128'h69c4e0d86a7b0430d8cdb78070b4c55a)
      else fail_now($sformatf("mismatch at %0t: fips result %h", $time, result));

    // twenty random keys and blocks
    for (int n = 0; n < 20; n++)
    begin
      make_random(k);
      make_random(b);
      run_op(k, b);
      wait_results();
    end

    // a start while busy is ignored
    make_random(k);
    make_random(b);
    run_op(k, b);
    repeat (5) @(negedge clk);
    assert (!ready)
      else fail_now("ready high while an operation runs");
    key = ~k;
    block = b ^ 128'h1;
    start = 1'b1;
    @(negedge clk);
    start = 1'b0;
    wait_results();
    // a second valid would find the queue empty
    repeat (60) @(negedge clk);

    // result hold and a start in the valid cycle
    held = result;
    repeat (10)
    begin
      @(negedge clk);
      assert (result == held)
        else fail_now($sformatf("mismatch at %0t: held result changed to %h", $time, result));
    end
    make_random(k);
    make_random(b);
    run_op(k, b);
    while (!valid)
    begin
      assert (result == held)
        else fail_now($sformatf("mismatch at %0t: result changed early to %h", $time, result));
      @(negedge clk);
    end
    assert (ready)
      else fail_now("ready low in the valid cycle");
    make_random(key);
    make_random(block);
    start = 1'b1;
    issued++;
    @(negedge clk);
    start = 1'b0;
    wait_results();
    @(negedge clk);

    if (done_count == num_ops && exp_q.size() == 0)
    begin
      $display("Verification passed");
      $finish;
    end
    else
    begin
      fail_now("number of completed operations is wrong");
    end
  end

endmodule

//--- vlog.f
+incdir+tests
design/aes_pkg.sv
design/aes_sbox_word.sv
design/aes_key_schedule.sv
design/aes_round_state.sv
design/aes_enc_ctrl.sv
design/aes_encipher.sv
tests/tb_aes_encipher.sv

//--- run.sh
#!/bin/sh
# build and run the aes-128 testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert --timing -f vlog.f --top-module tb_aes_encipher \
  -o sim_aes > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/sim_aes > sim.log 2>&1 || true
cat sim.log
grep -q "^Verification passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
